// ==== common/mpmc_chan_pkg.sv ====
`include "mpmc_settings.svh"

package mpmc_chan_pkg;

	// ======================================================================
	// Client channel side
	// ======================================================================

	// Channel number, also the tag carried through the request FIFO
	typedef logic [$clog2(`MPMC_NUM_CH)-1:0] chan_id_t;

	// One channel request
	// req is held high with all fields stable until ack is seen
	typedef struct packed {
		logic req;
		logic we;
		logic [`MPMC_CH_ADDR_W-1:0] adr;
		logic [`MPMC_SEL_W-1:0] sel;
		logic [`MPMC_DATA_W-1:0] dat;
	} chan_req_t;

	// One channel response
	// dat holds read data when ack rises for a read
	typedef struct packed {
		logic ack;
		logic [`MPMC_DATA_W-1:0] dat;
	} chan_resp_t;

endpackage

// ==== common/mpmc_mem_pkg.sv ====
`include "mpmc_settings.svh"

package mpmc_mem_pkg;

	import mpmc_chan_pkg::*;

	// ======================================================================
	// Memory side
	// ======================================================================

	// MIG application command codes
	typedef enum logic [2:0] {
		APP_CMD_WRITE = 3'd0,
		APP_CMD_READ  = 3'd1
	} app_cmd_e;

	// Sequencer states, one request at a time
	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WRITE_DATA,
		WAIT_READ,
		RESPOND
	} seq_state_e;

	// Queued request, tagged with the channel that made it
	typedef struct packed {
		chan_id_t chan;
		logic we;
		logic [`MPMC_CH_ADDR_W-1:0] adr;
		logic [`MPMC_SEL_W-1:0] sel;
		logic [`MPMC_DATA_W-1:0] dat;
	} fifo_entry_t;

endpackage

// ==== common/mpmc_settings.svh ====
`ifndef MPMC_SETTINGS_SVH
`define MPMC_SETTINGS_SVH

// ======================================================================
// Controller front end sizing
// ======================================================================

// Number of client channels
`define MPMC_NUM_CH 4

// One strip of memory data and its byte selects
`define MPMC_DATA_W 128
`define MPMC_SEL_W 16

// Channel byte address and MIG application address
`define MPMC_CH_ADDR_W 32
`define MPMC_APP_ADDR_W 29

// Request FIFO entries
`define MPMC_FIFO_DEPTH 8

`endif

// ==== design/mpmc_chan_arbiter.sv ====
`include "mpmc_settings.svh"

module mpmc_chan_arbiter import mpmc_chan_pkg::*, mpmc_mem_pkg::*;
(
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  chan_req_t ch_req [`MPMC_NUM_CH],
	input  logic full,
	output logic push,
	output fifo_entry_t entry
);

	// Set once a channel's request sits in the FIFO, cleared when req drops
	logic [`MPMC_NUM_CH-1:0] queued;
	logic [`MPMC_NUM_CH-1:0] pending;

	// Priority pointer, first channel looked at next time
	chan_id_t ptr;
	chan_id_t grant;
	chan_id_t cand;
	logic found;
	logic load;

	always_comb
	begin
		for (int i = 0; i < `MPMC_NUM_CH; i++)
		begin
			pending[i] = ch_req[i].req && !queued[i];
		end
	end

	// ======================================================================
	// Round-robin pick starting at the pointer
	// ======================================================================

	always_comb
	begin
		found = 1'b0;
		grant = ptr;
		cand = ptr;
		for (int k = 0; k < `MPMC_NUM_CH; k++)
		begin
			cand = chan_id_t'((int'(ptr) + k) % `MPMC_NUM_CH);
			if (!found && pending[cand])
			begin
				found = 1'b1;
				grant = cand;
			end
		end
	end

	// The output register takes a new grant when empty or being drained
	assign load = found && (!push || !full);

	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
		begin
			push <= 1'b0;
			queued <= '0;
			ptr <= '0;
		end
		else
		begin
			for (int i = 0; i < `MPMC_NUM_CH; i++)
			begin
				if (!ch_req[i].req)
					queued[i] <= 1'b0;
			end
			if (push && !full)
				push <= 1'b0;
			if (load)
			begin
				push <= 1'b1;
				queued[grant] <= 1'b1;
				ptr <= chan_id_t'((int'(grant) + 1) % `MPMC_NUM_CH);
			end
		end
	end

	// Entry is built from the granted channel's held request
	always_ff @(posedge mem_ui_clk)
	begin
		if (load)
		begin
			entry.chan <= grant;
			entry.we <= ch_req[grant].we;
			entry.adr <= ch_req[grant].adr;
			entry.sel <= ch_req[grant].sel;
			entry.dat <= ch_req[grant].dat;
		end
	end

endmodule

// ==== design/mpmc_ctrl.sv ====
`include "mpmc_settings.svh"

module mpmc_ctrl import mpmc_chan_pkg::*, mpmc_mem_pkg::*;
(
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic calib_complete,
	input  chan_req_t ch_req [`MPMC_NUM_CH],
	output chan_resp_t ch_resp [`MPMC_NUM_CH],
	input  logic app_rdy,
	output logic app_en,
	output app_cmd_e app_cmd,
	output logic [`MPMC_APP_ADDR_W-1:0] app_addr,
	input  logic app_wdf_rdy,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output logic [`MPMC_DATA_W-1:0] app_wdf_data,
	output logic [`MPMC_SEL_W-1:0] app_wdf_mask,
	input  logic app_rd_data_valid,
	input  logic [`MPMC_DATA_W-1:0] app_rd_data
);

	// Arbiter to FIFO
	logic push;
	fifo_entry_t entry;
	logic full;

	// FIFO to sequencer
	fifo_entry_t head;
	logic empty;
	logic pop;

	// Sequencer to router
	logic done;
	chan_id_t done_chan;
	logic [`MPMC_DATA_W-1:0] rd_dat;

	mpmc_chan_arbiter u_arb (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.ch_req     (ch_req),
		.full       (full),
		.push       (push),
		.entry      (entry)
	);

	mpmc_req_fifo u_fifo (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.push       (push),
		.din        (entry),
		.pop        (pop),
		.dout       (head),
		.full       (full),
		.empty      (empty)
	);

	mpmc_sequencer u_seq (
		.mem_ui_clk        (mem_ui_clk),
		.mem_ui_rst        (mem_ui_rst),
		.calib_complete    (calib_complete),
		.head              (head),
		.empty             (empty),
		.pop               (pop),
		.app_rdy           (app_rdy),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask      (app_wdf_mask),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.done              (done),
		.done_chan         (done_chan),
		.rd_dat            (rd_dat)
	);

	mpmc_resp_router u_router (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.ch_req     (ch_req),
		.done       (done),
		.done_chan  (done_chan),
		.rd_dat     (rd_dat),
		.ch_resp    (ch_resp)
	);

endmodule

// ==== design/mpmc_req_fifo.sv ====
`include "mpmc_settings.svh"

module mpmc_req_fifo import mpmc_mem_pkg::*;
(
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic push,
	input  fifo_entry_t din,
	input  logic pop,
	output fifo_entry_t dout,
	output logic full,
	output logic empty
);

	localparam int PTR_W = $clog2(`MPMC_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`MPMC_FIFO_DEPTH + 1);

	fifo_entry_t mem [`MPMC_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	assign full = (count == CNT_W'(`MPMC_FIFO_DEPTH));
	assign empty = (count == '0);

	// Head entry straight from the array
	assign dout = mem[rd_ptr];

	always_ff @(posedge mem_ui_clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(`MPMC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(`MPMC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== design/mpmc_resp_router.sv ====
`include "mpmc_settings.svh"

module mpmc_resp_router import mpmc_chan_pkg::*;
(
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  chan_req_t ch_req [`MPMC_NUM_CH],
	input  logic done,
	input  chan_id_t done_chan,
	input  logic [`MPMC_DATA_W-1:0] rd_dat,
	output chan_resp_t ch_resp [`MPMC_NUM_CH]
);

	logic [`MPMC_NUM_CH-1:0] ack;
	logic [`MPMC_DATA_W-1:0] dat [`MPMC_NUM_CH];

	// ======================================================================
	// Four-phase ack per channel
	// ======================================================================

	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
			ack <= '0;
		else
		begin
			for (int i = 0; i < `MPMC_NUM_CH; i++)
			begin
				// Dropped req wins so ack never rises without a request
				if (!ch_req[i].req)
					ack[i] <= 1'b0;
				else if (done && done_chan == chan_id_t'(i))
					ack[i] <= 1'b1;
			end
		end
	end

	// Read data for the finishing channel
	// the channel's we is still held, so writes keep the old value
	always_ff @(posedge mem_ui_clk)
	begin
		for (int i = 0; i < `MPMC_NUM_CH; i++)
		begin
			if (done && done_chan == chan_id_t'(i) && !ch_req[i].we)
				dat[i] <= rd_dat;
		end
	end

	always_comb
	begin
		for (int i = 0; i < `MPMC_NUM_CH; i++)
		begin
			ch_resp[i].ack = ack[i];
			ch_resp[i].dat = dat[i];
		end
	end

endmodule

// ==== mpmc_ctrl.f ====
+incdir+common
common/mpmc_chan_pkg.sv
common/mpmc_mem_pkg.sv
design/mpmc_chan_arbiter.sv
design/mpmc_req_fifo.sv
sequencer/mpmc_sequencer.sv
design/mpmc_resp_router.sv
design/mpmc_ctrl.sv
tb/mpmc_ctrl_assertions.sv
tb/tb_mpmc_ctrl.sv

// ==== sequencer/mpmc_sequencer.sv ====
`include "mpmc_settings.svh"

module mpmc_sequencer import mpmc_chan_pkg::*, mpmc_mem_pkg::*;
(
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic calib_complete,
	input  fifo_entry_t head,
	input  logic empty,
	output logic pop,
	input  logic app_rdy,
	output logic app_en,
	output app_cmd_e app_cmd,
	output logic [`MPMC_APP_ADDR_W-1:0] app_addr,
	input  logic app_wdf_rdy,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output logic [`MPMC_DATA_W-1:0] app_wdf_data,
	output logic [`MPMC_SEL_W-1:0] app_wdf_mask,
	input  logic app_rd_data_valid,
	input  logic [`MPMC_DATA_W-1:0] app_rd_data,
	output logic done,
	output chan_id_t done_chan,
	output logic [`MPMC_DATA_W-1:0] rd_dat
);

	seq_state_e state;

	// Request being worked on, loaded from the FIFO head
	fifo_entry_t cur;
	logic [`MPMC_DATA_W-1:0] wr_data;

	// Nothing leaves IDLE until the memory is calibrated
	assign pop = (state == IDLE) && calib_complete && !empty;

	// ======================================================================
	// State machine
	// ======================================================================

	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
			state <= IDLE;
		else
		begin
			case (state)
			IDLE:
				if (pop)
					state <= ISSUE;
			ISSUE:
				// Command holds until the controller takes it
				if (app_rdy)
					state <= cur.we ? WRITE_DATA : WAIT_READ;
			WRITE_DATA:
				if (app_wdf_rdy)
					state <= RESPOND;
			WAIT_READ:
				if (app_rd_data_valid)
					state <= RESPOND;
			RESPOND:
				state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge mem_ui_clk)
	begin
		if (pop)
			cur <= head;
	end

	always_ff @(posedge mem_ui_clk)
	begin
		if (state == WAIT_READ && app_rd_data_valid)
			rd_dat <= app_rd_data;
	end

	// ======================================================================
	// Application interface
	// ======================================================================

	assign app_en = (state == ISSUE);
	assign app_cmd = cur.we ? APP_CMD_WRITE : APP_CMD_READ;

	// 8-byte address units, strip aligned
	assign app_addr = {cur.adr[`MPMC_CH_ADDR_W-1:4], 1'b0};

	// Single strip, so end goes with every data beat
	assign app_wdf_wren = (state == WRITE_DATA);
	assign app_wdf_end = app_wdf_wren;

	// Mask bit set means the byte is not written
	assign app_wdf_mask = ~cur.sel;

	// Unselected lanes go out as all ones
	always_comb
	begin
		for (int b = 0; b < `MPMC_SEL_W; b++)
		begin
			wr_data[b*8 +: 8] = cur.sel[b] ? cur.dat[b*8 +: 8] : 8'hFF;
		end
	end

	assign app_wdf_data = wr_data;

	// Completion for the response router
	assign done = (state == RESPOND);
	assign done_chan = cur.chan;

endmodule

// ==== tb/mpmc_ctrl_assertions.sv ====
`include "mpmc_settings.svh"

module mpmc_ctrl_assertions import mpmc_chan_pkg::*, mpmc_mem_pkg::*;
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input logic calib_complete,
	input chan_req_t ch_req [`MPMC_NUM_CH],
	input chan_resp_t ch_resp [`MPMC_NUM_CH],
	input logic app_rdy,
	input logic app_en,
	input app_cmd_e app_cmd,
	input logic [`MPMC_APP_ADDR_W-1:0] app_addr,
	input logic app_wdf_rdy,
	input logic app_wdf_wren,
	input logic app_wdf_end,
	input logic [`MPMC_DATA_W-1:0] app_wdf_data,
	input logic [`MPMC_SEL_W-1:0] app_wdf_mask
);

	// True when every masked byte lane carries all ones
	function automatic logic lanes_ok(logic [`MPMC_DATA_W-1:0] d, logic [`MPMC_SEL_W-1:0] m);
		logic ok;
		ok = 1'b1;
		for (int b = 0; b < `MPMC_SEL_W; b++)
		begin
			if (m[b] && d[b*8 +: 8] != 8'hFF)
				ok = 1'b0;
		end
		return ok;
	endfunction

	// ======================================================================
	// Memory interface
	// ======================================================================

	// Channel tag sits in app_addr[10:9] for the testbench address map

	a_calib: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		!calib_complete |-> !app_en && !app_wdf_wren)
	else
	begin
		$error("app interface active before calib_complete");
		tb_mpmc_ctrl.err_count++;
	end

	a_cmd_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr))
	else
	begin
		$error("command or address changed while app_rdy was low");
		tb_mpmc_ctrl.err_count++;
	end

	a_wdf_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_wdf_wren && !app_wdf_rdy |=>
		app_wdf_wren && $stable(app_wdf_data) && $stable(app_wdf_mask))
	else
	begin
		$error("write data or mask changed while stalled");
		tb_mpmc_ctrl.err_count++;
	end

	a_wdf_end: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_wdf_end == app_wdf_wren)
	else
	begin
		$error("** Error app_wdf_end %h app_wdf_wren %h",
			$sampled(app_wdf_end), $sampled(app_wdf_wren));
		tb_mpmc_ctrl.err_count++;
	end

	a_mask: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_wdf_wren |-> app_wdf_mask == ~tb_mpmc_ctrl.cur_sel[app_addr[10:9]])
	else
	begin
		$error("** Error app_wdf_mask: got %h expected %h", app_wdf_mask,
			~tb_mpmc_ctrl.cur_sel[app_addr[10:9]]);
		tb_mpmc_ctrl.err_count++;
	end

	a_lanes: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_wdf_wren |-> lanes_ok(app_wdf_data, app_wdf_mask))
	else
	begin
		$error("** Error app_wdf_data masked lanes: %h mask %h", app_wdf_data, app_wdf_mask);
		tb_mpmc_ctrl.err_count++;
	end

	a_one_cmd: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_en && app_rdy |->
		tb_mpmc_ctrl.cmd_cnt[app_addr[10:9]] < tb_mpmc_ctrl.req_cnt[app_addr[10:9]])
	else
	begin
		$error("command accepted without an open request");
		tb_mpmc_ctrl.err_count++;
	end

	a_rotate: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_en && app_rdy && tb_mpmc_ctrl.rr_valid |-> app_addr[10:9] == tb_mpmc_ctrl.rr_next)
	else
	begin
		$error("** Error app_addr[10:9]: got %h expected %h", app_addr[10:9],
			$sampled(tb_mpmc_ctrl.rr_next));
		tb_mpmc_ctrl.err_count++;
	end

	// Per channel handshake and read data
	for (genvar i = 0; i < `MPMC_NUM_CH; i++)
	begin : g_ch
		a_ack_calib: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
			!calib_complete |-> !ch_resp[i].ack)
		else
		begin
			$error("ack before calib_complete");
			tb_mpmc_ctrl.err_count++;
		end

		a_ack_rise: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
			$rose(ch_resp[i].ack) |->
			$past(ch_req[i].req) && tb_mpmc_ctrl.cmd_cnt[i] == tb_mpmc_ctrl.req_cnt[i])
		else
		begin
			$error("ack rose without a matching request");
			tb_mpmc_ctrl.err_count++;
		end

		a_ack_fall: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
			ch_resp[i].ack && !ch_req[i].req |=> !ch_resp[i].ack)
		else
		begin
			$error("ack did not fall after req dropped");
			tb_mpmc_ctrl.err_count++;
		end

		a_rd_dat: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
			$rose(ch_resp[i].ack) && !ch_req[i].we |-> ch_resp[i].dat == tb_mpmc_ctrl.exp_rd[i])
		else
		begin
			$error("** Error ch_resp[%0d].dat: got %h expected %h", i, ch_resp[i].dat,
				tb_mpmc_ctrl.exp_rd[i]);
			tb_mpmc_ctrl.err_count++;
		end
	end

endmodule

// ==== tb/tb_mpmc_ctrl.sv ====
`include "mpmc_settings.svh"

module tb_mpmc_ctrl import mpmc_chan_pkg::*, mpmc_mem_pkg::*;
();

	localparam int REQS = 40;
	localparam int TIMEOUT_CYCLES = `MPMC_NUM_CH * REQS * 20;

	logic mem_ui_clk = 0;
	logic mem_ui_rst;
	logic calib_complete;
	chan_req_t ch_req [`MPMC_NUM_CH];
	chan_resp_t ch_resp [`MPMC_NUM_CH];
	logic app_rdy;
	logic app_en;
	logic app_wdf_rdy;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic app_rd_data_valid;
	app_cmd_e app_cmd;
	logic [`MPMC_APP_ADDR_W-1:0] app_addr;
	logic [`MPMC_DATA_W-1:0] app_wdf_data;
	logic [`MPMC_DATA_W-1:0] app_rd_data;
	logic [`MPMC_SEL_W-1:0] app_wdf_mask;

	// Shadow and memory model state, also read by the bound checker
	logic [7:0] shadow [bit [31:0]];
	logic [7:0] mem_bytes [bit [31:0]];
	logic [`MPMC_DATA_W-1:0] exp_rd [`MPMC_NUM_CH];
	logic [`MPMC_SEL_W-1:0] cur_sel [`MPMC_NUM_CH];
	int req_cnt [`MPMC_NUM_CH];
	int cmd_cnt [`MPMC_NUM_CH];
	int err_count = 0;
	int cycles = 0;
	logic rr_phase = 0;
	logic rr_valid = 0;
	logic [1:0] rr_next = 0;
	bit [31:0] wr_addr;
	bit [31:0] rd_addr;
	logic rd_pend = 0;
	int rd_wait;

	mpmc_ctrl dut_i (.*);

	bind mpmc_ctrl mpmc_ctrl_assertions u_chk (.*);

	always #4 mem_ui_clk = ~mem_ui_clk;

	// Initial contents depend on every address bit
	function automatic logic [7:0] init_byte(bit [31:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
	endfunction

	// ======================================================================
	// Memory model
	// ======================================================================

	always @(posedge mem_ui_clk)
	begin
		cycles++;
		if (app_en && app_rdy)
		begin
			cmd_cnt[app_addr[10:9]]++;
			if (rr_phase)
			begin
				rr_next = app_addr[10:9] + 2'd1;
				rr_valid = 1'b1;
			end
			if (app_cmd == APP_CMD_WRITE)
				wr_addr = {app_addr, 3'b000};
			else
			begin
				rd_addr = {app_addr, 3'b000};
				rd_wait = 2 + $urandom % 5;
				rd_pend = 1'b1;
			end
		end
		// Only bytes with a clear mask bit are written
		if (app_wdf_wren && app_wdf_rdy)
			for (int b = 0; b < `MPMC_SEL_W; b++)
				if (!app_wdf_mask[b])
					mem_bytes[wr_addr + b] = app_wdf_data[b*8 +: 8];
	end

	always @(negedge mem_ui_clk)
	begin
		app_rdy <= ($urandom % 4) != 0;
		app_wdf_rdy <= ($urandom % 4) != 0;
		app_rd_data_valid <= 1'b0;
		if (rd_pend && rd_wait > 1)
			rd_wait--;
		else if (rd_pend)
		begin
			rd_pend = 1'b0;
			app_rd_data_valid <= 1'b1;
			for (int b = 0; b < `MPMC_SEL_W; b++)
				app_rd_data[b*8 +: 8] <= mem_bytes.exists(rd_addr + b) ?
					mem_bytes[rd_addr + b] : init_byte(rd_addr + b);
		end
	end

	// One four-phase request, address tagged by channel in bits 13:12
	task automatic do_req(input int ch, input logic we, input int slot);
		bit [31:0] adr;
		logic [`MPMC_SEL_W-1:0] sel;
		logic [`MPMC_DATA_W-1:0] dat;
		adr = 32'h0040_0000 | (ch << 12) | (slot << 4);
		sel = `MPMC_SEL_W'($urandom);
		dat = {$urandom, $urandom, $urandom, $urandom};
		@(negedge mem_ui_clk);
		for (int b = 0; b < `MPMC_SEL_W; b++)
		begin
			if (we && sel[b])
				shadow[adr + b] = dat[b*8 +: 8];
			exp_rd[ch][b*8 +: 8] = shadow.exists(adr + b) ? shadow[adr + b] : init_byte(adr + b);
		end
		if (we)
			cur_sel[ch] = sel;
		ch_req[ch] = '{req: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
		req_cnt[ch]++;
		while (!ch_resp[ch].ack)
			@(negedge mem_ui_clk);
		ch_req[ch].req = 1'b0;
		while (ch_resp[ch].ack)
			@(negedge mem_ui_clk);
	endtask

	task automatic run_all(input int n, input logic mixed);
		for (int c = 0; c < `MPMC_NUM_CH; c++)
		begin
			fork
				automatic int cc = c;
				for (int k = 0; k < n; k++)
					do_req(cc, mixed ? logic'($urandom % 2) : logic'(k % 2 == 0), $urandom % 4);
			join_none
		end
		wait fork;
	endtask

	always @(posedge mem_ui_clk)
	begin
		if (err_count != 0)
		begin
			$display("*** FAILED ***");
			$fatal(1, "assertion failure");
		end
		else if (cycles > TIMEOUT_CYCLES)
		begin
			$display("*** FAILED ***");
			$fatal(1, "timeout: requests did not complete");
		end
	end

	initial
	begin
		void'($urandom(86681));
		mem_ui_rst = 1'b1;
		calib_complete = 1'b0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		for (int c = 0; c < `MPMC_NUM_CH; c++)
		begin
			ch_req[c] = '0;
			req_cnt[c] = 0;
			cmd_cnt[c] = 0;
			exp_rd[c] = '0;
			cur_sel[c] = '0;
		end
		repeat (16) @(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;
		// Requests queue up while calibration is still pending
		fork
			begin
				repeat (10) @(negedge mem_ui_clk);
				calib_complete = 1'b1;
			end
			run_all(24, 1'b1);
		join
		rr_phase = 1'b1;
		run_all(REQS - 24, 1'b0);
		repeat (4) @(negedge mem_ui_clk);
		if (err_count == 0)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
		begin
			$display("*** FAILED ***");
			$fatal(1, "checks failed");
		end
	end

endmodule
